//--- verilog/eeprom_pkg.sv
package eeprom_pkg;

    // one byte on the serial bus
    typedef logic [7:0] byte_t;

    // device type code in the upper nibble of every control byte
    localparam logic [3:0] device_code = 4'b1010;

    // lowest bit of the control byte
    localparam logic rw_read  = 1'b1;
    localparam logic rw_write = 1'b0;

    // control byte layout
    localparam int ctrl_dev_msb = 7;
    localparam int ctrl_dev_lsb = 4;
    localparam int ctrl_blk_msb = 3;
    localparam int ctrl_blk_lsb = 1;
    localparam int ctrl_rw_bit  = 0;

endpackage

//--- verilog/eeprom_array.sv
`timescale 1ns/1ps

module eeprom_array
#(
    parameter int addr_w = 11
)
(
    input  logic              scl,
    input  logic              mem_we,
    input  logic [addr_w-1:0] mem_addr,
    input  eeprom_pkg::byte_t mem_wdata,
    output eeprom_pkg::byte_t mem_rdata
);

    localparam int depth = 1 << addr_w;

    eeprom_pkg::byte_t mem [0:depth-1];

    // read returns the old byte on a same-cycle write
    always_ff @(posedge scl)
    begin
        if (mem_we)
            mem[mem_addr] <= mem_wdata;
        mem_rdata <= mem[mem_addr];
    end

endmodule

//--- verilog/eeprom_master.sv
`timescale 1ns/1ps

module eeprom_master
#(
    parameter int addr_w      = 11,
    parameter int half_period = 4
)
(
    input  logic              scl,
    input  logic              arst_n,
    input  logic              req_valid,
    input  logic              req_write,
    input  logic [addr_w-1:0] req_addr,
    input  eeprom_pkg::byte_t req_data,
    output logic              busy,
    output logic              done,
    output eeprom_pkg::byte_t rd_data,
    output logic              ser_clk,
    output logic              master_sda_low,
    input  logic              ser_data
);

    typedef enum logic [2:0] {m_idle, m_start, m_bits, m_rsetup, m_stop} state_t;

    localparam int cnt_w = $clog2(half_period);

    // byte segments of a transaction, in bus order
    localparam logic [2:0] seg_ctrl_w = 3'd0;
    localparam logic [2:0] seg_addr   = 3'd1;
    localparam logic [2:0] seg_data   = 3'd2;
    localparam logic [2:0] seg_ctrl_r = 3'd3;
    localparam logic [2:0] seg_rdata  = 3'd4;

    state_t            state;
    logic [cnt_w-1:0]  hcnt;
    logic              tick;
    logic              half;
    logic [2:0]        bitcnt;
    logic [2:0]        seg;
    logic [2:0]        nseg;
    logic              write_q;
    logic [10:0]       addr_ext;
    eeprom_pkg::byte_t data_q;
    eeprom_pkg::byte_t txsh;
    eeprom_pkg::byte_t rx;
    eeprom_pkg::byte_t load_byte;

    // byte sent in a given segment; read data phase leaves the line released
    function automatic eeprom_pkg::byte_t seg_byte(input logic [2:0] s);
        eeprom_pkg::byte_t b;
        b = 8'hff;
        if (s == seg_ctrl_w || s == seg_ctrl_r)
        begin
            b[eeprom_pkg::ctrl_dev_msb:eeprom_pkg::ctrl_dev_lsb] = eeprom_pkg::device_code;
            b[eeprom_pkg::ctrl_blk_msb:eeprom_pkg::ctrl_blk_lsb] = addr_ext[10:8];
            b[eeprom_pkg::ctrl_rw_bit] = (s == seg_ctrl_w) ? eeprom_pkg::rw_write
                                                           : eeprom_pkg::rw_read;
        end
        else if (s == seg_addr)
            b = addr_ext[7:0];
        else if (s == seg_data)
            b = data_q;
        return b;
    endfunction

    assign tick      = (hcnt == cnt_w'(half_period - 1));
    assign nseg      = (state == m_start) ? seg : seg + 3'd1;
    assign load_byte = seg_byte(nseg);

    // request capture
    always_ff @(posedge scl)
    begin
        if (state == m_idle && req_valid)
        begin
            write_q  <= req_write;
            addr_ext <= 11'(req_addr);
            data_q   <= req_data;
        end
    end

    always_ff @(posedge scl or negedge arst_n)
    begin
        if (!arst_n)
        begin
            state          <= m_idle;
            hcnt           <= '0;
            half           <= 1'b0;
            bitcnt         <= '0;
            seg            <= seg_ctrl_w;
            busy           <= 1'b0;
            done           <= 1'b0;
            ser_clk        <= 1'b1;
            master_sda_low <= 1'b0;
            txsh           <= '0;
            rx             <= '0;
            rd_data        <= '0;
        end
        else
        begin
            done <= 1'b0;
            if (state != m_idle)
                hcnt <= tick ? '0 : hcnt + 1'b1;
            case (state)
                m_idle:
                begin
                    if (req_valid)
                    begin
                        state          <= m_start;
                        busy           <= 1'b1;
                        seg            <= seg_ctrl_w;
                        master_sda_low <= 1'b1;
                    end
                end
                m_start:
                begin
                    // sda went low with ser_clk high, now enter the first bit
                    if (tick)
                    begin
                        ser_clk        <= 1'b0;
                        half           <= 1'b0;
                        bitcnt         <= '0;
                        state          <= m_bits;
                        txsh           <= load_byte;
                        master_sda_low <= ~load_byte[7];
                    end
                end
                m_bits:
                begin
                    if (tick)
                    begin
                        if (!half)
                        begin
                            ser_clk <= 1'b1;
                            half    <= 1'b1;
                            if (seg == seg_rdata)
                                rx <= {rx[6:0], ser_data};
                        end
                        else if (bitcnt != 3'd7)
                        begin
                            ser_clk        <= 1'b0;
                            half           <= 1'b0;
                            bitcnt         <= bitcnt + 3'd1;
                            txsh           <= {txsh[6:0], 1'b1};
                            master_sda_low <= ~txsh[6];
                        end
                        else
                        begin
                            ser_clk <= 1'b0;
                            half    <= 1'b0;
                            bitcnt  <= '0;
                            if (seg == seg_data || seg == seg_rdata)
                            begin
                                state          <= m_stop;
                                master_sda_low <= 1'b1;
                            end
                            else if (seg == seg_addr && !write_q)
                            begin
                                state          <= m_rsetup;
                                seg            <= seg_ctrl_r;
                                master_sda_low <= 1'b0;
                            end
                            else
                            begin
                                seg            <= nseg;
                                txsh           <= load_byte;
                                master_sda_low <= ~load_byte[7];
                            end
                        end
                    end
                end
                m_rsetup:
                begin
                    // released line, raise ser_clk, then repeated start
                    if (tick)
                    begin
                        if (!half)
                        begin
                            ser_clk <= 1'b1;
                            half    <= 1'b1;
                        end
                        else
                        begin
                            state          <= m_start;
                            master_sda_low <= 1'b1;
                        end
                    end
                end
                m_stop:
                begin
                    if (tick)
                    begin
                        if (!half)
                        begin
                            ser_clk <= 1'b1;
                            half    <= 1'b1;
                        end
                        else
                        begin
                            // sda rises with ser_clk high
                            state          <= m_idle;
                            master_sda_low <= 1'b0;
                            busy           <= 1'b0;
                            done           <= 1'b1;
                            if (!write_q)
                                rd_data <= rx;
                        end
                    end
                end
                default:
                    state <= m_idle;
            endcase
        end
    end

endmodule

//--- verilog/eeprom_slave.sv
`timescale 1ns/1ps

module eeprom_slave
#(
    parameter int addr_w = 11
)
(
    input  logic              scl,
    input  logic              arst_n,
    input  logic              ser_clk,
    input  logic              ser_data,
    output logic              slave_sda_low,
    output logic              mem_we,
    output logic [addr_w-1:0] mem_addr,
    output eeprom_pkg::byte_t mem_wdata,
    input  eeprom_pkg::byte_t mem_rdata
);

    typedef enum logic [2:0] {s_idle, s_ctrl, s_addr, s_data, s_send} state_t;

    state_t            state;
    logic              clk_d;
    logic              sda_d;
    logic              clk_rise;
    logic              clk_fall;
    logic              start_seen;
    logic              stop_seen;
    logic              byte_end;
    logic [3:0]        cnt;
    logic [10:0]       full_addr;
    eeprom_pkg::byte_t shreg;
    eeprom_pkg::byte_t rx_byte;
    eeprom_pkg::byte_t ctrl_q;
    eeprom_pkg::byte_t addr_q;

    assign clk_rise   = ser_clk & ~clk_d;
    assign clk_fall   = ~ser_clk & clk_d;
    // sda edges only count while ser_clk stays high
    assign start_seen = clk_d & ser_clk & sda_d & ~ser_data;
    assign stop_seen  = clk_d & ser_clk & ~sda_d & ser_data;
    assign byte_end   = clk_rise && cnt == 4'd7;
    assign rx_byte    = {shreg[6:0], ser_data};

    // block select joined with the address byte
    assign full_addr = {ctrl_q[eeprom_pkg::ctrl_blk_msb:eeprom_pkg::ctrl_blk_lsb], addr_q};
    assign mem_addr  = full_addr[addr_w-1:0];

    always_ff @(posedge scl)
    begin
        if (clk_rise)
            shreg <= rx_byte;
        if (byte_end && state == s_ctrl)
            ctrl_q <= rx_byte;
        if (byte_end && state == s_addr)
            addr_q <= rx_byte;
        if (byte_end && state == s_data)
            mem_wdata <= rx_byte;
    end

    always_ff @(posedge scl or negedge arst_n)
    begin
        if (!arst_n)
        begin
            clk_d         <= 1'b1;
            sda_d         <= 1'b1;
            state         <= s_idle;
            cnt           <= '0;
            mem_we        <= 1'b0;
            slave_sda_low <= 1'b0;
        end
        else
        begin
            clk_d  <= ser_clk;
            sda_d  <= ser_data;
            mem_we <= 1'b0;
            if (stop_seen)
            begin
                state         <= s_idle;
                slave_sda_low <= 1'b0;
            end
            else if (start_seen)
            begin
                state         <= s_ctrl;
                cnt           <= '0;
                slave_sda_low <= 1'b0;
            end
            else if (state == s_send)
            begin
                // new bit after each ser_clk fall, released after the eighth
                if (clk_fall)
                begin
                    if (cnt == 4'd8)
                    begin
                        slave_sda_low <= 1'b0;
                        state         <= s_idle;
                    end
                    else
                    begin
                        slave_sda_low <= ~mem_rdata[3'd7 - cnt[2:0]];
                        cnt           <= cnt + 4'd1;
                    end
                end
            end
            else if (state != s_idle && clk_rise)
            begin
                cnt <= cnt + 4'd1;
                if (cnt == 4'd7)
                begin
                    cnt <= '0;
                    if (state == s_ctrl)
                    begin
                        if (rx_byte[eeprom_pkg::ctrl_rw_bit] == eeprom_pkg::rw_read)
                            state <= s_send;
                        else
                            state <= s_addr;
                    end
                    else if (state == s_addr)
                        state <= s_data;
                    else
                    begin
                        state  <= s_idle;
                        mem_we <= 1'b1;
                    end
                end
            end
        end
    end

endmodule

//--- verilog/eeprom_subsys.sv
`timescale 1ns/1ps

module eeprom_subsys
#(
    parameter int addr_w      = 11,
    parameter int half_period = 4
)
(
    input  logic              scl,
    input  logic              arst_n,
    input  logic              req_valid,
    input  logic              req_write,
    input  logic [addr_w-1:0] req_addr,
    input  eeprom_pkg::byte_t req_data,
    output logic              busy,
    output logic              done,
    output eeprom_pkg::byte_t rd_data,
    output logic              ser_clk,
    output logic              ser_data
);

    logic              master_sda_low;
    logic              slave_sda_low;
    logic              mem_we;
    logic [addr_w-1:0] mem_addr;
    eeprom_pkg::byte_t mem_wdata;
    eeprom_pkg::byte_t mem_rdata;

    // open-drain bus, high unless a side pulls low
    assign ser_data = ~(master_sda_low | slave_sda_low);

    eeprom_master
    #(
        .addr_w      (addr_w),
        .half_period (half_period)
    )
    eeprom_master_inst
    (
        .scl            (scl),
        .arst_n         (arst_n),
        .req_valid      (req_valid),
        .req_write      (req_write),
        .req_addr       (req_addr),
        .req_data       (req_data),
        .busy           (busy),
        .done           (done),
        .rd_data        (rd_data),
        .ser_clk        (ser_clk),
        .master_sda_low (master_sda_low),
        .ser_data       (ser_data)
    );

    eeprom_slave
    #(
        .addr_w (addr_w)
    )
    eeprom_slave_inst
    (
        .scl           (scl),
        .arst_n        (arst_n),
        .ser_clk       (ser_clk),
        .ser_data      (ser_data),
        .slave_sda_low (slave_sda_low),
        .mem_we        (mem_we),
        .mem_addr      (mem_addr),
        .mem_wdata     (mem_wdata),
        .mem_rdata     (mem_rdata)
    );

    eeprom_array
    #(
        .addr_w (addr_w)
    )
    eeprom_array_inst
    (
        .scl       (scl),
        .mem_we    (mem_we),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata),
        .mem_rdata (mem_rdata)
    );

endmodule

//--- sim/eeprom_subsys_tb.sv
`timescale 1ns/1ps

module eeprom_subsys_tb;

    localparam int addr_w       = 11;
    localparam int half_period  = 4;
    localparam int clk_period   = 100;
    localparam int drive_delay  = 10;
    // longest frame is a read, 38 bit times
    localparam int frame_cycles = 38 * 2 * half_period;
    // transactions per test, in run order
    localparam int n_trans      = 2 + 6 + 3 + 4 + 40;
    localparam longint watchdog_ns = longint'(n_trans) * frame_cycles * clk_period * 2;

    logic              scl;
    logic              arst_n;
    logic              req_valid;
    logic              req_write;
    logic [addr_w-1:0] req_addr;
    eeprom_pkg::byte_t req_data;
    logic              busy;
    logic              done;
    eeprom_pkg::byte_t rd_data;
    logic              ser_clk;
    logic              ser_data;

    integer            seed;
    eeprom_pkg::byte_t ref_mem [0:(1 << addr_w)-1];

    eeprom_subsys
    #(
        .addr_w      (addr_w),
        .half_period (half_period)
    )
    eeprom_subsys_inst
    (
        .scl       (scl),
        .arst_n    (arst_n),
        .req_valid (req_valid),
        .req_write (req_write),
        .req_addr  (req_addr),
        .req_data  (req_data),
        .busy      (busy),
        .done      (done),
        .rd_data   (rd_data),
        .ser_clk   (ser_clk),
        .ser_data  (ser_data)
    );

    initial
    begin
        scl = 1'b0;
        forever #(clk_period / 2) scl = ~scl;
    end

    initial
    begin
        #(watchdog_ns);
        $display("timeout: the run went past its time limit without finishing");
        $display("Verification failed");
        $fatal(1);
    end

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp)
        begin
            $display("** Error: %s got 0x%0h, expected 0x%0h at %0t", name, got, exp, $time);
            $display("Verification failed");
            $fatal(1);
        end
    endtask

    task automatic check_byte(input string name, input eeprom_pkg::byte_t got,
                              input eeprom_pkg::byte_t exp);
        if (got !== exp)
        begin
            $display("** Error: %s got 0x%0h, expected 0x%0h at %0t", name, got, exp, $time);
            $display("Verification failed");
            $fatal(1);
        end
    endtask

    // one-cycle strobe, then busy must follow
    task automatic send_request(input logic write, input logic [addr_w-1:0] addr,
                                input eeprom_pkg::byte_t data);
        @(posedge scl);
        #drive_delay;
        req_valid = 1'b1;
        req_write = write;
        req_addr  = addr;
        req_data  = data;
        @(posedge scl);
        #drive_delay;
        req_valid = 1'b0;
        @(negedge scl);
        check_bit("busy", busy, 1'b1);
    endtask

    task automatic wait_for_done;
        int cycles;
        cycles = 0;
        while (done !== 1'b1)
        begin
            if (cycles == 2 * frame_cycles)
            begin
                $display("timeout: no done strobe after %0d cycles", cycles);
                $display("Verification failed");
                $fatal(1);
            end
            @(negedge scl);
            cycles++;
        end
        check_bit("busy", busy, 1'b0);
    endtask

    task automatic do_write(input logic [addr_w-1:0] addr, input eeprom_pkg::byte_t data);
        send_request(1'b1, addr, data);
        wait_for_done();
        ref_mem[addr] = data;
    endtask

    // rd_data sampled in the done cycle
    task automatic do_read(input logic [addr_w-1:0] addr, output eeprom_pkg::byte_t data);
        send_request(1'b0, addr, 8'h00);
        wait_for_done();
        data = rd_data;
    endtask

    task automatic test_reset_state;
        check_bit("busy", busy, 1'b0);
        check_bit("done", done, 1'b0);
        check_bit("ser_clk", ser_clk, 1'b1);
        check_bit("ser_data", ser_data, 1'b1);
    endtask

    task automatic test_write_read;
        eeprom_pkg::byte_t got;
        do_write(11'h03a, 8'hc5);
        do_read(11'h03a, got);
        check_byte("rd_data", got, 8'hc5);
    endtask

    // same low byte, different block select
    task automatic test_block_select;
        eeprom_pkg::byte_t got;
        do_write(11'h055, 8'h11);
        do_write(11'h355, 8'h22);
        do_write(11'h755, 8'h33);
        do_read(11'h055, got);
        check_byte("rd_data", got, 8'h11);
        do_read(11'h355, got);
        check_byte("rd_data", got, 8'h22);
        do_read(11'h755, got);
        check_byte("rd_data", got, 8'h33);
    endtask

    task automatic test_overwrite;
        eeprom_pkg::byte_t got;
        do_write(11'h0f0, 8'h5a);
        do_write(11'h0f0, 8'ha5);
        do_read(11'h0f0, got);
        check_byte("rd_data", got, 8'ha5);
    endtask

    task automatic test_busy_strobe;
        eeprom_pkg::byte_t got;
        do_write(11'h200, 8'h3c);
        send_request(1'b1, 11'h201, 8'h96);
        repeat (20) @(posedge scl);
        @(negedge scl);
        check_bit("busy", busy, 1'b1);
        // this one should be dropped
        @(posedge scl);
        #drive_delay;
        req_valid = 1'b1;
        req_write = 1'b1;
        req_addr  = 11'h200;
        req_data  = 8'hff;
        @(posedge scl);
        #drive_delay;
        req_valid = 1'b0;
        wait_for_done();
        ref_mem[11'h201] = 8'h96;
        repeat (2 * frame_cycles)
        begin
            @(negedge scl);
            check_bit("done", done, 1'b0);
            check_bit("busy", busy, 1'b0);
        end
        do_read(11'h200, got);
        check_byte("rd_data", got, 8'h3c);
        do_read(11'h201, got);
        check_byte("rd_data", got, 8'h96);
    endtask

    task automatic test_random_traffic;
        logic [addr_w-1:0] addrs [$];
        logic [addr_w-1:0] a;
        eeprom_pkg::byte_t d;
        eeprom_pkg::byte_t got;
        for (int i = 0; i < 20; i++)
        begin
            a = addr_w'($random(seed));
            d = 8'($random(seed));
            do_write(a, d);
            addrs.push_back(a);
        end
        foreach (addrs[i])
        begin
            do_read(addrs[i], got);
            check_byte("rd_data", got, ref_mem[addrs[i]]);
        end
    endtask

    initial
    begin
        seed      = 32'h8219;
        arst_n    = 1'b0;
        req_valid = 1'b0;
        req_write = 1'b0;
        req_addr  = '0;
        req_data  = '0;
        repeat (2) @(posedge scl);
        #drive_delay;
        arst_n = 1'b1;
        @(negedge scl);

        test_reset_state();
        test_write_read();
        test_block_select();
        test_overwrite();
        test_busy_strobe();
        test_random_traffic();

        $display("Verification passed");
        $finish;
    end

endmodule

//--- eeprom_subsys.f
verilog/eeprom_pkg.sv
verilog/eeprom_array.sv
verilog/eeprom_master.sv
verilog/eeprom_slave.sv
verilog/eeprom_subsys.sv
sim/eeprom_subsys_tb.sv

//--- Makefile
VERILATOR  = verilator
TOP        = eeprom_subsys_tb
RTL_TOP    = eeprom_subsys
FILELIST   = eeprom_subsys.f
OBJ_DIR    = obj_dir
LOG        = sim.log
PASS_MSG   = Verification passed
VFLAGS     = --binary --timing -j 0
LINT_FLAGS = --lint-only -Wall --timing

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "simulation did not pass, see $(LOG)"; exit 1)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
